// File: build.f
hdl/vmul_pkg.sv
hdl/vedic_mul_unsigned.sv
hdl/vmul_apb_regs.sv
hdl/vmul_decode.sv
hdl/vmul_execute.sv
hdl/vmul_result.sv
hdl/vmul_top.sv
tb/vmul_tb.sv

// File: hdl/vedic_mul_unsigned.sv
// Recursive unsigned vedic multiplier
// Splits both operands in halves, forms four quarter products
// and merges them with a low, a middle and a high addition
`default_nettype none

module vedic_mul_unsigned #(
    parameter int WIDTH     = 8,
    parameter int MIN_WIDTH = 2
) (
    input  wire logic [WIDTH-1:0]   a,
    input  wire logic [WIDTH-1:0]   b,
    output logic      [2*WIDTH-1:0] z
);

    localparam int HALF = WIDTH / 2;

    if ((WIDTH < 2) || ((WIDTH & (WIDTH - 1)) != 0)) begin : gen_width_check
        $fatal(1, "WIDTH must be a power of two, WIDTH: %0d", WIDTH);
    end

    if ((WIDTH > MIN_WIDTH) && (WIDTH > 2)) begin : gen_split
        logic [HALF-1:0]  a_l;
        logic [HALF-1:0]  a_h;
        logic [HALF-1:0]  b_l;
        logic [HALF-1:0]  b_h;
        logic [WIDTH-1:0] mul_ll;
        logic [WIDTH-1:0] mul_lh;
        logic [WIDTH-1:0] mul_hl;
        logic [WIDTH-1:0] mul_hh;
        logic [WIDTH:0]   mid_sum;
        logic [WIDTH:0]   low_sum;
        logic [WIDTH-1:0] high_sum;
        logic             carry;

        assign a_l = a[HALF-1:0];
        assign a_h = a[WIDTH-1:HALF];
        assign b_l = b[HALF-1:0];
        assign b_h = b[WIDTH-1:HALF];

        vedic_mul_unsigned #(.WIDTH(HALF), .MIN_WIDTH(MIN_WIDTH)) u_mul_ll (
            .a(a_l), .b(b_l), .z(mul_ll)
        );
        vedic_mul_unsigned #(.WIDTH(HALF), .MIN_WIDTH(MIN_WIDTH)) u_mul_lh (
            .a(a_l), .b(b_h), .z(mul_lh)
        );
        vedic_mul_unsigned #(.WIDTH(HALF), .MIN_WIDTH(MIN_WIDTH)) u_mul_hl (
            .a(a_h), .b(b_l), .z(mul_hl)
        );
        vedic_mul_unsigned #(.WIDTH(HALF), .MIN_WIDTH(MIN_WIDTH)) u_mul_hh (
            .a(a_h), .b(b_h), .z(mul_hh)
        );

        // Cross terms first, then fold in the upper half of the low product
        assign mid_sum = {1'b0, mul_lh} + {1'b0, mul_hl};
        assign low_sum = {1'b0, {HALF{1'b0}}, mul_ll[WIDTH-1:HALF]} + {1'b0, mid_sum[WIDTH-1:0]};

        // The two carries are never set together
        assign carry    = low_sum[WIDTH] | mid_sum[WIDTH];
        assign high_sum = {{(HALF-1){1'b0}}, carry, low_sum[WIDTH-1:HALF]} + mul_hh;

        assign z = {high_sum, low_sum[HALF-1:0], mul_ll[HALF-1:0]};
    end else if (WIDTH == 2) begin : gen_base2
        logic t_hl;
        logic t_lh;
        logic t_hh;
        logic c1;

        assign t_hl = a[1] & b[0];
        assign t_lh = a[0] & b[1];
        assign t_hh = a[1] & b[1];
        assign c1   = t_hl & t_lh;

        assign z[0] = a[0] & b[0];
        assign z[1] = t_hl ^ t_lh;
        assign z[2] = t_hh ^ c1;
        assign z[3] = t_hh & c1;
    end else begin : gen_base
        // Larger base case left to the synthesis multiplier
        assign z = a * b;
    end

endmodule

`default_nettype wire

// File: hdl/vmul_apb_regs.sv
// APB register block of the vector multiply unit
// Holds operands, launches requests on CTRL writes, tracks requests
// in flight and captures the result and status
`default_nettype none

module vmul_apb_regs import vmul_pkg::*; (
    input  wire logic [ADDR_W-1:0] paddr,
    input  wire logic              clk_i,
    input  wire logic              arst_n,
    input  wire logic              psel,
    input  wire logic              penable,
    input  wire logic              pwrite,
    input  wire logic [DATA_W-1:0] pwdata,
    output logic      [DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    output vmul_req_t              req,
    output logic                   start,
    input  wire vmul_res_t         res
);

    localparam int CNT_W = 3;

    logic              access;
    logic              map_hit;
    logic              ro_hit;
    logic              wr_en;
    logic [DATA_W-1:0] opa_q;
    logic [DATA_W-1:0] opb_q;
    vmul_op_t          op_q;
    vmul_sew_t         sew_q;
    logic              done_q;
    logic              illegal_q;
    logic [DATA_W-1:0] result_q;
    logic [CNT_W-1:0]  inflight_q;
    vmul_status_t      status;

    assign access  = psel && penable;
    assign map_hit = (paddr == REG_OPA) || (paddr == REG_OPB) || (paddr == REG_CTRL) ||
                     (paddr == REG_STATUS) || (paddr == REG_RESULT);
    assign ro_hit  = (paddr == REG_STATUS) || (paddr == REG_RESULT);

    assign pready  = 1'b1;
    assign pslverr = access && (!map_hit || (pwrite && ro_hit));
    assign wr_en   = access && pwrite && map_hit && !ro_hit;
    assign start   = wr_en && (paddr == REG_CTRL);

    // Control fields go straight from the write data into the request
    assign req.a   = opa_q;
    assign req.b   = opb_q;
    assign req.op  = vmul_op_t'(pwdata[1:0]);
    assign req.sew = vmul_sew_t'(pwdata[5:4]);

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            opa_q <= '0;
            opb_q <= '0;
            op_q  <= VMUL_LO;
            sew_q <= SEW_8;
        end else if (wr_en) begin
            case (paddr)
                REG_OPA: opa_q <= pwdata;
                REG_OPB: opb_q <= pwdata;
                REG_CTRL: begin
                    op_q  <= req.op;
                    sew_q <= req.sew;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            done_q     <= 1'b0;
            illegal_q  <= 1'b0;
            result_q   <= '0;
            inflight_q <= '0;
        end else begin
            case ({start, res.valid})
                2'b10:   inflight_q <= inflight_q + CNT_W'(1);
                2'b01:   inflight_q <= inflight_q - CNT_W'(1);
                default: ;
            endcase
            if (res.valid) begin
                illegal_q <= res.illegal;
                result_q  <= res.data;
            end
            // A new request hides the completion of an older one
            if (start) begin
                done_q <= 1'b0;
            end else if (res.valid) begin
                done_q <= 1'b1;
            end
        end
    end

    assign status.busy    = (inflight_q != '0);
    assign status.illegal = illegal_q;
    assign status.done    = done_q;

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                REG_OPA:    prdata = opa_q;
                REG_OPB:    prdata = opb_q;
                REG_CTRL:   prdata = DATA_W'({sew_q, 2'b00, op_q});
                REG_STATUS: prdata = DATA_W'(status);
                REG_RESULT: prdata = result_q;
                default:    prdata = '0;
            endcase
        end
    end

    // Three pipeline stages bound the number of requests in flight
    a_inflight_max: assert property (@(posedge clk_i) disable iff (!arst_n)
        inflight_q <= CNT_W'(3));

endmodule

`default_nettype wire

// File: hdl/vmul_decode.sv
// Decode stage of the vector multiply pipeline
// Checks opcode and element width and registers the decoded request
`default_nettype none

module vmul_decode import vmul_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      arst_n,
    input  wire vmul_req_t req,
    input  wire logic      start,
    output vmul_dec_t      dec
);

    logic       op_ok;
    logic [2:0] wsel;
    vmul_dec_t  dec_d;
    vmul_dec_t  dec_q;
    logic       valid_q;

    assign op_ok = (req.op == VMUL_LO) || (req.op == VMUL_HI);

    always_comb begin
        case (req.sew)
            SEW_8:   wsel = 3'b001;
            SEW_16:  wsel = 3'b010;
            SEW_32:  wsel = 3'b100;
            default: wsel = 3'b000;
        endcase
    end

    always_comb begin
        dec_d.valid   = start;
        dec_d.illegal = !op_ok || (wsel == 3'b000);
        dec_d.a       = req.a;
        dec_d.b       = req.b;
        dec_d.op      = req.op;
        dec_d.wsel    = wsel;
    end

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= start;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            dec_q <= dec_d;
        end
    end

    always_comb begin
        dec       = dec_q;
        dec.valid = valid_q;
    end

endmodule

`default_nettype wire

// File: hdl/vmul_execute.sv
// Execute stage of the vector multiply pipeline
// Runs 8, 16 and 32 bit lanes of vedic multipliers in parallel and
// registers the product group picked by the width select
`default_nettype none

module vmul_execute import vmul_pkg::*; #(
    parameter int VLEN      = 32,
    parameter int MIN_WIDTH = 2
) (
    input  wire logic      clk_i,
    input  wire logic      arst_n,
    input  wire vmul_dec_t dec,
    output vmul_prod_t     prod
);

    localparam int N8   = VLEN / 8;
    localparam int N16  = VLEN / 16;
    localparam int PW8  = f_prod_width(8);
    localparam int PW16 = f_prod_width(16);
    localparam int PW32 = f_prod_width(32);

    logic [2*VLEN-1:0] lane8_p;
    logic [2*VLEN-1:0] lane16_p;
    logic [2*VLEN-1:0] lane32_p;
    vmul_prod_t        prod_d;
    vmul_prod_t        prod_q;
    logic              valid_q;

    if (VLEN != DATA_W) begin : gen_vlen_check
        $fatal(1, "VLEN %0d does not match the register width %0d", VLEN, DATA_W);
    end

    for (genvar i = 0; i < N8; i++) begin : gen_lane8
        vedic_mul_unsigned #(.WIDTH(8), .MIN_WIDTH(MIN_WIDTH)) u_mul (
            .a(dec.a[8*i +: 8]),
            .b(dec.b[8*i +: 8]),
            .z(lane8_p[PW8*i +: PW8])
        );
    end

    for (genvar i = 0; i < N16; i++) begin : gen_lane16
        vedic_mul_unsigned #(.WIDTH(16), .MIN_WIDTH(MIN_WIDTH)) u_mul (
            .a(dec.a[16*i +: 16]),
            .b(dec.b[16*i +: 16]),
            .z(lane16_p[PW16*i +: PW16])
        );
    end

    vedic_mul_unsigned #(.WIDTH(32), .MIN_WIDTH(MIN_WIDTH)) u_mul32 (
        .a(dec.a),
        .b(dec.b),
        .z(lane32_p[PW32-1:0])
    );

    always_comb begin
        prod_d.valid   = dec.valid;
        prod_d.illegal = dec.illegal;
        prod_d.op      = dec.op;
        prod_d.wsel    = dec.wsel;
        if (dec.wsel[WSEL_8]) begin
            prod_d.prod = lane8_p;
        end else if (dec.wsel[WSEL_16]) begin
            prod_d.prod = lane16_p;
        end else begin
            prod_d.prod = lane32_p;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= dec.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec.valid) begin
            prod_q <= prod_d;
        end
    end

    always_comb begin
        prod       = prod_q;
        prod.valid = valid_q;
    end

    // Decode must hand over exactly one width for a legal request
    a_wsel_onehot: assert property (@(posedge clk_i) disable iff (!arst_n)
        (dec.valid && !dec.illegal) |-> $onehot(dec.wsel));

endmodule

`default_nettype wire

// File: hdl/vmul_pkg.sv
// Vector multiply unit shared definitions
// Opcode and element width encodings, stage structs and APB register map
`default_nettype none

package vmul_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 5;

    typedef enum logic [1:0] {
        VMUL_LO    = 2'b00,
        VMUL_HI    = 2'b01,
        VMUL_RSV_2 = 2'b10,
        VMUL_RSV_3 = 2'b11
    } vmul_op_t;

    typedef enum logic [1:0] {
        SEW_8   = 2'b00,
        SEW_16  = 2'b01,
        SEW_32  = 2'b10,
        SEW_RSV = 2'b11
    } vmul_sew_t;

    // Bit positions in the one-hot width select
    localparam int WSEL_8  = 0;
    localparam int WSEL_16 = 1;
    localparam int WSEL_32 = 2;

    typedef struct packed {
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        vmul_op_t          op;
        vmul_sew_t         sew;
    } vmul_req_t;

    typedef struct packed {
        logic              valid;
        logic              illegal;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        vmul_op_t          op;
        logic [2:0]        wsel;
    } vmul_dec_t;

    // Products sit at twice the element position
    typedef struct packed {
        logic                valid;
        logic                illegal;
        vmul_op_t            op;
        logic [2:0]          wsel;
        logic [2*DATA_W-1:0] prod;
    } vmul_prod_t;

    typedef struct packed {
        logic              valid;
        logic              illegal;
        logic [DATA_W-1:0] data;
    } vmul_res_t;

    typedef struct packed {
        logic busy;
        logic illegal;
        logic done;
    } vmul_status_t;

    localparam logic [ADDR_W-1:0] REG_OPA    = 5'h00;
    localparam logic [ADDR_W-1:0] REG_OPB    = 5'h04;
    localparam logic [ADDR_W-1:0] REG_CTRL   = 5'h08;
    localparam logic [ADDR_W-1:0] REG_STATUS = 5'h0C;
    localparam logic [ADDR_W-1:0] REG_RESULT = 5'h10;

    function automatic int f_prod_width(input int sew_bits);
        return 2 * sew_bits;
    endfunction

endpackage

`default_nettype wire

// File: hdl/vmul_result.sv
// Result stage of the vector multiply pipeline
// Picks the low or high half of every element product and packs them
`default_nettype none

module vmul_result import vmul_pkg::*; #(
    parameter int VLEN = 32
) (
    input  wire logic       clk_i,
    input  wire logic       arst_n,
    input  wire vmul_prod_t prod,
    output vmul_res_t       res
);

    logic            hi;
    logic [VLEN-1:0] data_d;
    vmul_res_t       res_d;
    vmul_res_t       res_q;
    logic            valid_q;

    // Element e of width ew has its product at bit 2*ew*e
    function automatic logic [VLEN-1:0] pack_halves(
        input logic [2*VLEN-1:0] p,
        input int                ew,
        input logic              sel_hi
    );
        logic [VLEN-1:0] r;
        r = '0;
        for (int i = 0; i < VLEN; i++) begin
            r[i] = p[(i / ew) * 2 * ew + (sel_hi ? ew : 0) + (i % ew)];
        end
        return r;
    endfunction

    assign hi = (prod.op == VMUL_HI);

    always_comb begin
        data_d = '0;
        if (!prod.illegal) begin
            if (prod.wsel[WSEL_8]) begin
                data_d = pack_halves(prod.prod, 8, hi);
            end else if (prod.wsel[WSEL_16]) begin
                data_d = pack_halves(prod.prod, 16, hi);
            end else if (prod.wsel[WSEL_32]) begin
                data_d = pack_halves(prod.prod, 32, hi);
            end
        end
    end

    assign res_d.valid   = prod.valid;
    assign res_d.illegal = prod.illegal;
    assign res_d.data    = data_d;

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= prod.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (prod.valid) begin
            res_q <= res_d;
        end
    end

    always_comb begin
        res       = res_q;
        res.valid = valid_q;
    end

endmodule

`default_nettype wire

// File: hdl/vmul_top.sv
// Vector integer multiply unit on APB
// APB register block feeding a decode, execute and result pipeline
`default_nettype none

module vmul_top import vmul_pkg::*; #(
    parameter int VLEN      = 32,
    parameter int MIN_WIDTH = 2
) (
    input  wire logic              clk_i,
    input  wire logic              arst_n,
    input  wire logic [ADDR_W-1:0] paddr,
    input  wire logic              psel,
    input  wire logic              penable,
    input  wire logic              pwrite,
    input  wire logic [DATA_W-1:0] pwdata,
    output logic      [DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr
);

    vmul_req_t  req;
    logic       start;
    vmul_dec_t  dec;
    vmul_prod_t prod;
    vmul_res_t  res;

    vmul_apb_regs u_regs (
        .clk_i   (clk_i),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .req     (req),
        .start   (start),
        .res     (res)
    );

    vmul_decode u_decode (
        .clk_i  (clk_i),
        .arst_n (arst_n),
        .req    (req),
        .start  (start),
        .dec    (dec)
    );

    vmul_execute #(.VLEN(VLEN), .MIN_WIDTH(MIN_WIDTH)) u_execute (
        .clk_i  (clk_i),
        .arst_n (arst_n),
        .dec    (dec),
        .prod   (prod)
    );

    vmul_result #(.VLEN(VLEN)) u_result (
        .clk_i  (clk_i),
        .arst_n (arst_n),
        .prod   (prod),
        .res    (res)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the vector multiply testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module vmul_tb -f build.f -o vmul_sim; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/vmul_sim)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

// File: tb/vmul_tb.sv
// Testbench for the APB vector multiply unit
// Applies a table of operand rows and checks results against a reference model
`default_nettype none

module vmul_tb import vmul_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SEED     = 40863;
    localparam int N_RANDOM = 24;

    typedef struct packed {
        logic [DATA_W-1:0] opa;
        logic [DATA_W-1:0] opb;
        vmul_op_t          op;
        vmul_sew_t         sew;
        logic              illegal;
    } row_t;

    logic              clk_i = 1'b0;
    logic              arst_n;
    logic [ADDR_W-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;

    row_t rows[$];
    int   mismatch_cnt = 0;
    int   other_cnt = 0;
    int   cycle_cnt = 0;
    int   timeout_cycles = 1000;

    vmul_top #(.VLEN(32), .MIN_WIDTH(2)) vmul_top_i (
        .clk_i   (clk_i),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic compare_data(input string name, input logic [DATA_W-1:0] exp,
                                input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("mismatch %s expected 0x%h actual 0x%h", name, exp, act);
        end
    endtask

    task automatic compare_status(input string name, input vmul_status_t exp,
                                  input vmul_status_t act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("mismatch %s expected 0x%h actual 0x%h", name, exp, act);
        end
    endtask

    task automatic compare_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatch_cnt++;
            $display("mismatch %s expected 0x%h actual 0x%h", name, exp, act);
        end
    endtask

    // Both bus tasks start and end 1 ns after a rising edge
    task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic exp_err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk_i);
        #1;
        penable = 1'b1;
        #2;
        compare_err("pslverr", exp_err, pslverr);
        @(posedge clk_i);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                            input logic exp_err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk_i);
        #1;
        penable = 1'b1;
        #2;
        compare_err("pready", 1'b1, pready);
        compare_err("pslverr", exp_err, pslverr);
        data = prdata;
        @(posedge clk_i);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    function automatic logic [DATA_W-1:0] ctrl_word(input vmul_op_t op, input vmul_sew_t sew);
        return {26'd0, sew, 2'b00, op};
    endfunction

    function automatic logic is_illegal(input vmul_op_t op, input vmul_sew_t sew);
        return (op == VMUL_RSV_2) || (op == VMUL_RSV_3) || (sew == SEW_RSV);
    endfunction

    // Unsigned element products at twice the element width
    function automatic logic [DATA_W-1:0] expected_result(input row_t r);
        int                ew;
        logic [63:0]       mask;
        logic [63:0]       ea;
        logic [63:0]       eb;
        logic [63:0]       p;
        logic [63:0]       half;
        logic [DATA_W-1:0] acc;
        acc = '0;
        if (!r.illegal) begin
            ew   = (r.sew == SEW_8) ? 8 : (r.sew == SEW_16) ? 16 : 32;
            mask = (64'd1 << ew) - 64'd1;
            for (int e = 0; e < DATA_W / ew; e++) begin
                ea   = (64'(r.opa) >> (e * ew)) & mask;
                eb   = (64'(r.opb) >> (e * ew)) & mask;
                p    = ea * eb;
                half = (r.op == VMUL_HI) ? ((p >> ew) & mask) : (p & mask);
                acc  = acc | DATA_W'(half << (e * ew));
            end
        end
        return acc;
    endfunction

    function automatic row_t make_row(input logic [DATA_W-1:0] opa, input logic [DATA_W-1:0] opb,
                                      input vmul_op_t op, input vmul_sew_t sew,
                                      input logic illegal);
        row_t r;
        r.opa     = opa;
        r.opb     = opb;
        r.op      = op;
        r.sew     = sew;
        r.illegal = illegal;
        return r;
    endfunction

    task automatic build_table();
        row_t r;
        rows.push_back(make_row(32'h0, 32'h0, VMUL_LO, SEW_8, 1'b0));
        rows.push_back(make_row(32'hffffffff, 32'h0, VMUL_HI, SEW_16, 1'b0));
        rows.push_back(make_row(32'hffffffff, 32'hffffffff, VMUL_LO, SEW_8, 1'b0));
        rows.push_back(make_row(32'hffffffff, 32'hffffffff, VMUL_HI, SEW_8, 1'b0));
        rows.push_back(make_row(32'hffffffff, 32'hffffffff, VMUL_LO, SEW_16, 1'b0));
        rows.push_back(make_row(32'hffffffff, 32'hffffffff, VMUL_HI, SEW_16, 1'b0));
        rows.push_back(make_row(32'hffffffff, 32'hffffffff, VMUL_LO, SEW_32, 1'b0));
        rows.push_back(make_row(32'hffffffff, 32'hffffffff, VMUL_HI, SEW_32, 1'b0));
        rows.push_back(make_row(32'h12345678, 32'h9abcdef0, VMUL_HI, SEW_32, 1'b0));
        // Reserved codes, each followed by a legal request
        rows.push_back(make_row(32'h01020304, 32'h05060708, VMUL_RSV_2, SEW_8, 1'b1));
        rows.push_back(make_row(32'h01020304, 32'h05060708, VMUL_LO, SEW_8, 1'b0));
        rows.push_back(make_row(32'h0000ffff, 32'h0000ffff, VMUL_HI, SEW_RSV, 1'b1));
        rows.push_back(make_row(32'h80007fff, 32'h8000ffff, VMUL_HI, SEW_16, 1'b0));
        rows.push_back(make_row(32'hdeadbeef, 32'h00000003, VMUL_RSV_3, SEW_32, 1'b1));
        rows.push_back(make_row(32'hdeadbeef, 32'h00000003, VMUL_LO, SEW_32, 1'b0));
        for (int i = 0; i < N_RANDOM; i++) begin
            r.opa     = $urandom;
            r.opb     = $urandom;
            r.op      = vmul_op_t'($urandom % 2);
            r.sew     = vmul_sew_t'($urandom % 3);
            r.illegal = is_illegal(r.op, r.sew);
            rows.push_back(r);
        end
    endtask

    task automatic wait_done();
        logic [DATA_W-1:0] rd;
        vmul_status_t      st;
        int                polls;
        polls = 0;
        st    = '0;
        while (!(st.done && !st.busy) && polls < 16) begin
            apb_read(REG_STATUS, rd, 1'b0);
            st = vmul_status_t'(rd[2:0]);
            polls++;
        end
        if (!(st.done && !st.busy)) begin
            other_cnt++;
            $display("request did not complete: done bit never set with the unit idle");
        end
    endtask

    task automatic apply_row(input row_t r);
        logic [DATA_W-1:0] rd;
        vmul_status_t      exp_st;
        apb_write(REG_OPA, r.opa, 1'b0);
        apb_write(REG_OPB, r.opb, 1'b0);
        apb_write(REG_CTRL, ctrl_word(r.op, r.sew), 1'b0);
        wait_done();
        exp_st.busy    = 1'b0;
        exp_st.illegal = r.illegal;
        exp_st.done    = 1'b1;
        apb_read(REG_STATUS, rd, 1'b0);
        compare_status("status", exp_st, vmul_status_t'(rd[2:0]));
        apb_read(REG_RESULT, rd, 1'b0);
        compare_data("result", expected_result(r), rd);
        apb_read(REG_OPA, rd, 1'b0);
        compare_data("opa", r.opa, rd);
        apb_read(REG_OPB, rd, 1'b0);
        compare_data("opb", r.opb, rd);
    endtask

    // Done must still be low after the third edge and set after the fourth
    task automatic check_latency(input row_t r);
        logic [DATA_W-1:0] rd;
        row_t              flip;
        flip    = r;
        flip.op = (r.op == VMUL_HI) ? VMUL_LO : VMUL_HI;
        apb_write(REG_OPA, r.opa, 1'b0);
        apb_write(REG_OPB, r.opb, 1'b0);
        apb_write(REG_CTRL, ctrl_word(r.op, r.sew), 1'b0);
        @(posedge clk_i);
        #1;
        apb_read(REG_STATUS, rd, 1'b0);
        compare_status("status at edge 3", 3'b100, vmul_status_t'(rd[2:0]));
        wait_done();
        // Second request flips the op so the result register changes
        apb_write(REG_CTRL, ctrl_word(flip.op, flip.sew), 1'b0);
        repeat (2) @(posedge clk_i);
        #1;
        apb_read(REG_STATUS, rd, 1'b0);
        compare_status("status at edge 4", 3'b001, vmul_status_t'(rd[2:0]));
        apb_read(REG_RESULT, rd, 1'b0);
        compare_data("result at edge 4", expected_result(flip), rd);
    endtask

    task automatic check_back_to_back();
        logic [DATA_W-1:0] rd;
        row_t              first;
        row_t              second;
        first  = make_row(32'hfedc1234, 32'h89ab0f0f, VMUL_LO, SEW_16, 1'b0);
        second = make_row(32'hfedc1234, 32'h89ab0f0f, VMUL_HI, SEW_16, 1'b0);
        apb_write(REG_OPA, first.opa, 1'b0);
        apb_write(REG_OPB, first.opb, 1'b0);
        apb_write(REG_CTRL, ctrl_word(first.op, first.sew), 1'b0);
        apb_write(REG_CTRL, ctrl_word(second.op, second.sew), 1'b0);
        // This read lands right after the first request completes
        apb_read(REG_RESULT, rd, 1'b0);
        compare_data("first result", expected_result(first), rd);
        wait_done();
        apb_read(REG_RESULT, rd, 1'b0);
        compare_data("second result", expected_result(second), rd);
    endtask

    task automatic check_bus_errors();
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] last_result;
        apb_read(REG_RESULT, last_result, 1'b0);
        apb_read(5'h14, rd, 1'b1);
        apb_read(5'h02, rd, 1'b1);
        apb_write(5'h1c, 32'h5a5a5a5a, 1'b1);
        apb_write(REG_STATUS, 32'h7, 1'b1);
        apb_write(REG_RESULT, ~last_result, 1'b1);
        apb_read(REG_RESULT, rd, 1'b0);
        compare_data("result after write", last_result, rd);
    endtask

    initial begin
        logic [DATA_W-1:0] rd;
        arst_n  = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        void'($urandom(SEED));
        build_table();
        timeout_cycles = 40 * rows.size() + 200;

        repeat (16) @(posedge clk_i);
        #1;
        arst_n = 1'b1;
        compare_data("prdata", '0, prdata);
        compare_err("pslverr", 1'b0, pslverr);
        apb_read(REG_STATUS, rd, 1'b0);
        compare_status("status after reset", 3'b000, vmul_status_t'(rd[2:0]));

        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
        end

        check_latency(make_row(32'h11223344, 32'h55667788, VMUL_HI, SEW_8, 1'b0));
        check_back_to_back();
        check_bus_errors();

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
